/* logic/soc_bus_pkg.sv */
// soc bus package: bus widths, memory map, bank geometry and the address union
package soc_bus_pkg;

    ////////////////////
    // bus widths
    ////////////////////

    localparam int bus_width      = 32;
    localparam int bytes_per_word = bus_width / 8;
    localparam int offset_width   = $clog2(bytes_per_word);

    typedef logic [bus_width-1:0]      bus_word_t;
    // any set bit marks a write
    typedef logic [bytes_per_word-1:0] bus_strb_t;

    ////////////////////
    // bank geometry
    ////////////////////

    localparam int num_banks       = 4;
    localparam int ram_region_size = 4096;
    // 1024 words spread over the banks
    localparam int bank_words      = ram_region_size / (num_banks * bytes_per_word);
    localparam int bank_addr_width = $clog2(bank_words);
    localparam int bank_sel_width  = $clog2(num_banks);

    typedef logic [bank_sel_width-1:0] bank_sel_t;

    ////////////////////
    // memory map
    ////////////////////

    // ram occupies [0, ram_region_size)
    localparam bus_word_t sysinfo_addr = 32'h1000_0000;
    // returned by the sysinfo word
    localparam bus_word_t sys_clk_hz   = 32'd50_000_000;

    localparam int region_width = bus_width - bank_sel_width - bank_addr_width - offset_width;

    // byte address, or the same word split into its decode fields
    typedef union packed {
        logic [bus_width-1:0] raw;
        struct packed {
            logic [region_width-1:0]    region;
            bank_sel_t                  bank;
            logic [bank_addr_width-1:0] word;
            logic [offset_width-1:0]    offset;
        } fields;
    } bus_addr_t;

endpackage

/* logic/bus_decoder.sv */
// bus decoder: steers requests to ram banks, answers sysinfo and unmapped accesses
`timescale 1ns/1ps

module bus_decoder (
    input  logic                                   clk,
    input  logic                                   resetn,
    input  logic                                   cpu_valid,
    input  soc_bus_pkg::bus_strb_t                 cpu_wstrb,
    input  soc_bus_pkg::bus_addr_t                 cpu_addr,
    input  soc_bus_pkg::bus_word_t                 cpu_wdata,
    input  logic                                   cpu_ready,
    output logic [soc_bus_pkg::num_banks-1:0]      bank_valid,
    output logic [soc_bus_pkg::bank_addr_width-1:0] bank_word,
    output soc_bus_pkg::bus_strb_t                 bank_wstrb,
    output soc_bus_pkg::bus_word_t                 bank_wdata,
    output logic                                   dec_ready,
    output soc_bus_pkg::bus_word_t                 dec_rdata,
    output logic                                   cpu_fault
);

    import soc_bus_pkg::*;

    logic issue;
    logic is_write;
    logic is_ram;
    logic is_sysinfo;
    logic sys_ready;
    logic sys_read;

    ////////////////////
    // request decode
    ////////////////////

    // held request must not issue again in its ready cycle
    assign issue    = cpu_valid && !cpu_ready;
    assign is_write = |cpu_wstrb;

    assign is_ram     = (cpu_addr.fields.region == '0);
    assign is_sysinfo = (cpu_addr.raw == sysinfo_addr);

    always_comb begin
        for (int i = 0; i < num_banks; i++) begin
            bank_valid[i] = issue && is_ram && (cpu_addr.fields.bank == bank_sel_t'(i));
        end
    end

    // shared payload, qualified by bank_valid
    assign bank_word  = cpu_addr.fields.word;
    assign bank_wstrb = cpu_wstrb;
    assign bank_wdata = cpu_wdata;

    ////////////////////
    // local responses
    ////////////////////

    always_ff @(posedge clk) begin
        if (!resetn) begin
            sys_ready <= 1'b0;
            sys_read  <= 1'b0;
            cpu_fault <= 1'b0;
        end else begin
            sys_ready <= issue && is_sysinfo;
            // writes to sysinfo are dropped
            sys_read  <= issue && is_sysinfo && !is_write;
            cpu_fault <= issue && !is_ram && !is_sysinfo;
        end
    end

    // fault answers with zero data
    assign dec_ready = sys_ready || cpu_fault;
    assign dec_rdata = sys_read ? sys_clk_hz : '0;

endmodule

/* logic/ram_bank.sv */
// ram bank: byte-writable word memory with registered read data and ready
`timescale 1ns/1ps

module ram_bank (
    input  logic                                    clk,
    input  logic                                    resetn,
    input  logic                                    valid,
    input  logic [soc_bus_pkg::bank_addr_width-1:0] word,
    input  soc_bus_pkg::bus_strb_t                  wstrb,
    input  soc_bus_pkg::bus_word_t                  wdata,
    output logic                                    ready,
    output soc_bus_pkg::bus_word_t                  rdata
);

    import soc_bus_pkg::*;

    bus_word_t mem [bank_words];

    ////////////////////
    // storage
    ////////////////////

    // read sees the word before this cycle's write
    always_ff @(posedge clk) begin
        if (valid) begin
            for (int b = 0; b < bytes_per_word; b++) begin
                if (wstrb[b]) begin
                    mem[word][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
            rdata <= mem[word];
        end
    end

    ////////////////////
    // handshake
    ////////////////////

    // one cycle after the strobe
    always_ff @(posedge clk) begin
        if (!resetn) begin
            ready <= 1'b0;
        end else begin
            ready <= valid;
        end
    end

endmodule

/* logic/response_mux.sv */
// response mux: merges per-target ready and read data into the cpu response
`timescale 1ns/1ps

module response_mux (
    input  logic [soc_bus_pkg::num_banks-1:0] bank_ready,
    input  soc_bus_pkg::bus_word_t            bank_rdata [soc_bus_pkg::num_banks],
    input  logic                              dec_ready,
    input  soc_bus_pkg::bus_word_t            dec_rdata,
    output logic                              cpu_ready,
    output soc_bus_pkg::bus_word_t            cpu_rdata
);

    import soc_bus_pkg::*;

    logic hit;

    ////////////////////
    // ready merge
    ////////////////////

    // only one target answers per request
    assign cpu_ready = (|bank_ready) || dec_ready;

    ////////////////////
    // data select
    ////////////////////

    // banks first, then the decoder
    always_comb begin
        hit       = 1'b0;
        cpu_rdata = '0;
        for (int i = 0; i < num_banks; i++) begin
            if (!hit && bank_ready[i]) begin
                cpu_rdata = bank_rdata[i];
                hit       = 1'b1;
            end
        end
        if (!hit && dec_ready) begin
            cpu_rdata = dec_rdata;
        end
    end

endmodule

/* logic/mem_subsystem.sv */
// memory subsystem top: decoder, ram banks and response mux on the cpu data bus
`timescale 1ns/1ps

module mem_subsystem (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic                   cpu_valid,
    input  soc_bus_pkg::bus_strb_t cpu_wstrb,
    input  soc_bus_pkg::bus_addr_t cpu_addr,
    input  soc_bus_pkg::bus_word_t cpu_wdata,
    output logic                   cpu_ready,
    output soc_bus_pkg::bus_word_t cpu_rdata,
    output logic                   cpu_fault
);

    import soc_bus_pkg::*;

    logic [num_banks-1:0]       bank_valid;
    logic [bank_addr_width-1:0] bank_word;
    bus_strb_t                  bank_wstrb;
    bus_word_t                  bank_wdata;
    logic [num_banks-1:0]       bank_ready;
    bus_word_t                  bank_rdata [num_banks];
    logic                       dec_ready;
    bus_word_t                  dec_rdata;

    bus_decoder decoder_i (
        .clk        (clk),
        .resetn     (resetn),
        .cpu_valid  (cpu_valid),
        .cpu_wstrb  (cpu_wstrb),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .cpu_ready  (cpu_ready),
        .bank_valid (bank_valid),
        .bank_word  (bank_word),
        .bank_wstrb (bank_wstrb),
        .bank_wdata (bank_wdata),
        .dec_ready  (dec_ready),
        .dec_rdata  (dec_rdata),
        .cpu_fault  (cpu_fault)
    );

    ////////////////////
    // ram banks
    ////////////////////

    for (genvar i = 0; i < num_banks; i++) begin : bank_g
        ram_bank bank_i (
            .clk    (clk),
            .resetn (resetn),
            .valid  (bank_valid[i]),
            .word   (bank_word),
            .wstrb  (bank_wstrb),
            .wdata  (bank_wdata),
            .ready  (bank_ready[i]),
            .rdata  (bank_rdata[i])
        );
    end

    response_mux mux_i (
        .bank_ready (bank_ready),
        .bank_rdata (bank_rdata),
        .dec_ready  (dec_ready),
        .dec_rdata  (dec_rdata),
        .cpu_ready  (cpu_ready),
        .cpu_rdata  (cpu_rdata)
    );

endmodule

/* tb/clock_gen.sv */
// clock source for the testbench, 4 ns period
`timescale 1ns/1ps

module clock_gen (
    output logic clk
);

    // half period of 2 ns
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

endmodule

/* tb/mem_subsystem_assertions.sv */
// handshake and fault checks on the cpu side of the memory subsystem
`timescale 1ns/1ps

module mem_subsystem_assertions (
    input logic                   clk,
    input logic                   resetn,
    input logic                   cpu_valid,
    input logic                   cpu_ready,
    input soc_bus_pkg::bus_word_t cpu_rdata,
    input logic                   cpu_fault
);

    // polled by the testbench between accesses
    int unsigned failures = 0;

    ////////////////////
    // handshake
    ////////////////////

    // a held request gets a single ready pulse
    single_ready: assert property (@(posedge clk) disable iff (!resetn)
        (cpu_valid && cpu_ready) |=> !cpu_ready)
    else begin
        failures++;
        $error("cpu_ready high on two cycles in a row");
    end

    // fixed one-cycle latency
    ready_latency: assert property (@(posedge clk) disable iff (!resetn)
        (cpu_valid && !cpu_ready) |=> cpu_ready)
    else begin
        failures++;
        $error("cpu_ready missing one cycle after the request");
    end

    // a fault answers with ready and zero data
    fault_with_ready: assert property (@(posedge clk) disable iff (!resetn)
        cpu_fault |-> (cpu_ready && cpu_rdata == '0))
    else begin
        failures++;
        $error("cpu_fault without cpu_ready or with nonzero cpu_rdata");
    end

endmodule

/* tb/tb_mem_subsystem.sv */
// testbench for the memory subsystem: table-driven accesses against a byte-lane model
`timescale 1ns/1ps

module tb_mem_subsystem;

    import soc_bus_pkg::*;

    typedef struct packed {
        bus_strb_t wstrb;
        bus_addr_t addr;
        bus_word_t wdata;
        bus_word_t exp_rdata;
        logic      check_data;
        logic      exp_fault;
    } entry_t;

    localparam int reset_cycles = 10;

    logic      clk;
    logic      resetn;
    logic      cpu_valid;
    bus_strb_t cpu_wstrb;
    bus_addr_t cpu_addr;
    bus_word_t cpu_wdata;
    logic      cpu_ready;
    bus_word_t cpu_rdata;
    logic      cpu_fault;

    entry_t    stim_q [$];
    bus_word_t ram_model [num_banks * bank_words];
    logic      ram_known [num_banks * bank_words];
    bus_word_t lcg_state = 32'ha808_159f;
    int        cycle_count = 0;
    int        timeout_limit = 0;

    clock_gen clock_i (.clk(clk));

    mem_subsystem dut_i (
        .clk       (clk),
        .resetn    (resetn),
        .cpu_valid (cpu_valid),
        .cpu_wstrb (cpu_wstrb),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_ready (cpu_ready),
        .cpu_rdata (cpu_rdata),
        .cpu_fault (cpu_fault)
    );

    bind mem_subsystem mem_subsystem_assertions assertions_i (
        .clk       (clk),
        .resetn    (resetn),
        .cpu_valid (cpu_valid),
        .cpu_ready (cpu_ready),
        .cpu_rdata (cpu_rdata),
        .cpu_fault (cpu_fault)
    );

    ////////////////////
    // helpers
    ////////////////////

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_word(input bus_word_t actual, input bus_word_t expected);
        if (actual !== expected)
            abort_run($sformatf("error at time %0t: cpu_rdata is %h, expected %h",
                                $time, actual, expected));
    endtask

    task automatic check_fault(input logic actual, input logic expected);
        if (actual !== expected)
            abort_run($sformatf("error at time %0t: cpu_fault is %b, expected %b",
                                $time, actual, expected));
    endtask

    function automatic bus_word_t next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic bus_word_t ram_addr(input int bank, input int word);
        bus_addr_t a;
        a.raw         = '0;
        a.fields.bank = bank_sel_t'(bank);
        a.fields.word = word[bank_addr_width-1:0];
        return a.raw;
    endfunction

    // appends one access, expected values come from the memory model
    function automatic void add_access(input bus_strb_t wstrb, input bus_word_t raw,
                                       input bus_word_t wdata);
        entry_t    e;
        bus_addr_t a;
        int        idx;
        a.raw        = raw;
        idx          = int'({a.fields.bank, a.fields.word});
        e.wstrb      = wstrb;
        e.addr       = a;
        e.wdata      = wdata;
        e.exp_rdata  = '0;
        e.check_data = 1'b1;
        e.exp_fault  = 1'b0;
        if (a.fields.region == '0) begin
            // a write answers with the old word
            e.exp_rdata  = ram_model[idx];
            e.check_data = ram_known[idx];
            for (int b = 0; b < bytes_per_word; b++) begin
                if (wstrb[b])
                    ram_model[idx][8*b +: 8] = wdata[8*b +: 8];
            end
            if (wstrb == 4'b1111)
                ram_known[idx] = 1'b1;
        end else if (raw == sysinfo_addr) begin
            e.exp_rdata = (wstrb == 4'b0000) ? sys_clk_hz : '0;
        end else begin
            e.exp_fault = 1'b1;
        end
        stim_q.push_back(e);
    endfunction

    function automatic void build_table();
        int words [3];
        words = '{0, bank_words / 2, bank_words - 1};
        for (int b = 0; b < num_banks; b++)
            foreach (words[k]) add_access(4'b1111, ram_addr(b, words[k]), next_rand());
        for (int b = 0; b < num_banks; b++)
            foreach (words[k]) add_access(4'b0000, ram_addr(b, words[k]), '0);
        // byte and half-word merges
        for (int n = 1; n <= 2; n++) begin
            foreach (words[k]) begin
                if (k < 2) begin
                    add_access(4'b0001, ram_addr(n, words[k]), next_rand());
                    add_access(4'b0000, ram_addr(n, words[k]), '0);
                    add_access(4'b0100, ram_addr(n, words[k]), next_rand());
                    add_access(4'b1100, ram_addr(n, words[k]), next_rand());
                    add_access(4'b0011, ram_addr(n, words[k]), next_rand());
                    add_access(4'b0000, ram_addr(n, words[k]), '0);
                end
            end
        end
        add_access(4'b0000, sysinfo_addr, '0);
        add_access(4'b1111, sysinfo_addr, next_rand());
        add_access(4'b0000, sysinfo_addr, '0);
        // unmapped, then ram words that alias the same low bits
        add_access(4'b0000, 32'h0000_1000, '0);
        add_access(4'b1111, 32'h0000_1000, next_rand());
        add_access(4'b0000, 32'h2000_0000, '0);
        add_access(4'b1111, 32'h2000_0ffc, next_rand());
        add_access(4'b0000, ram_addr(0, 0), '0);
        add_access(4'b0000, ram_addr(num_banks - 1, bank_words - 1), '0);
    endfunction

    task automatic run_access(input entry_t e);
        int cycles;
        @(posedge clk);
        cpu_valid <= 1'b1;
        cpu_wstrb <= e.wstrb;
        cpu_addr  <= e.addr;
        cpu_wdata <= e.wdata;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (cpu_ready !== 1'b1);
        // sampled at the next edge, answered one cycle later
        if (cycles != 2)
            abort_run($sformatf("error at time %0t: cpu_ready after %0d cycles, expected 2",
                                $time, cycles));
        if (e.check_data)
            check_word(cpu_rdata, e.exp_rdata);
        check_fault(cpu_fault, e.exp_fault);
        if (dut_i.assertions_i.failures != 0)
            abort_run("a bound handshake assertion failed");
        cpu_valid <= 1'b0;
    endtask

    ////////////////////
    // run control
    ////////////////////

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= timeout_limit)
            abort_run($sformatf("simulation timed out after %0d cycles", cycle_count));
    end

    initial begin
        resetn    = 1'b0;
        cpu_valid = 1'b0;
        cpu_wstrb = '0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        for (int i = 0; i < num_banks * bank_words; i++)
            ram_known[i] = 1'b0;
        build_table();
        timeout_limit = reset_cycles + 4 * stim_q.size() + 50;

        repeat (reset_cycles) @(posedge clk);
        resetn <= 1'b1;

        // idle bus stays quiet
        repeat (3) begin
            @(posedge clk);
            if (cpu_ready !== 1'b0)
                abort_run($sformatf("error at time %0t: cpu_ready high with no request", $time));
            check_fault(cpu_fault, 1'b0);
        end

        foreach (stim_q[i]) run_access(stim_q[i]);

        repeat (2) @(posedge clk);
        if (dut_i.assertions_i.failures != 0) begin
            abort_run("a bound handshake assertion failed");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

/* list.f */
logic/soc_bus_pkg.sv
logic/bus_decoder.sv
logic/ram_bank.sv
logic/response_mux.sv
logic/mem_subsystem.sv
tb/clock_gen.sv
tb/mem_subsystem_assertions.sv
tb/tb_mem_subsystem.sv

/* Makefile */
# Verilator build, run and lint for the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_subsystem
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
JOBS      ?= 0
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  := Test failed
PASS_MSG  := Test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
